// File: hw/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    // Processor word width
    localparam int xlen = 32;

    // One cache line matches one Wishbone transfer
    localparam int line_bits = 64;

    // Direct-mapped geometry
    localparam int num_lines = 16;

    // Address fields from top to bottom are tag, index and offset
    localparam int offset_bits = 3;
    localparam int index_bits = 4;
    localparam int tag_bits = xlen - index_bits - offset_bits;

endpackage

// File: hw/lsu_op_pkg.sv
package lsu_op_pkg;

    // Load/store access size with bit 2 as the zero-extension flag for loads
    typedef enum logic [2:0] {
        size_b  = 3'b000,
        size_h  = 3'b001,
        size_w  = 3'b010,
        size_bu = 3'b100,
        size_hu = 3'b101
    } mem_size_e;

    // Bus controller states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_fill  = 2'd1,
        st_store = 2'd2,
        st_done  = 2'd3
    } ctrl_state_e;

    // Byte-lane masks for one 32-bit word before the shift by addr[1:0]
    localparam logic [3:0] sel_byte = 4'b0001;
    localparam logic [3:0] sel_half = 4'b0011;
    localparam logic [3:0] sel_word = 4'b1111;

endpackage

// File: hw/dcache_array.sv
`timescale 1ns/1ps

module dcache_array (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [dcache_cfg_pkg::xlen-1:0]      addr,
    output logic                               hit,
    output logic [dcache_cfg_pkg::line_bits-1:0] line_data,
    input  logic                               fill_en,
    input  logic [dcache_cfg_pkg::line_bits-1:0] fill_data,
    input  logic                               store_en,
    input  logic [dcache_cfg_pkg::xlen-1:0]      wdata,
    input  lsu_op_pkg::mem_size_e              size
);

    import dcache_cfg_pkg::*;
    import lsu_op_pkg::*;

    logic [num_lines-1:0] valid;
    logic [tag_bits-1:0]  tag_mem  [num_lines];
    logic [line_bits-1:0] data_mem [num_lines];

    logic [tag_bits-1:0]    line_tag;
    logic [index_bits-1:0]  line_idx;
    logic [offset_bits-1:0] line_off;

    logic [3:0]           lane_mask;
    logic [3:0]           lane_sel;
    logic [7:0]           byte_sel;
    logic [xlen-1:0]      wdata_lane;
    logic [line_bits-1:0] store_line;

    assign line_tag = addr[xlen-1 -: tag_bits];
    assign line_idx = addr[offset_bits +: index_bits];
    assign line_off = addr[offset_bits-1:0];

    // Combinational lookup
    assign hit       = valid[line_idx] && (tag_mem[line_idx] == line_tag);
    assign line_data = data_mem[line_idx];

    // Bytes touched by a store
    always_comb begin
        case (size)
            size_b, size_bu: lane_mask = sel_byte;
            size_h, size_hu: lane_mask = sel_half;
            default:         lane_mask = sel_word;
        endcase
    end

    assign lane_sel   = lane_mask << line_off[1:0];
    assign byte_sel   = line_off[2] ? {lane_sel, 4'b0000} : {4'b0000, lane_sel};
    assign wdata_lane = wdata << {line_off[1:0], 3'b000};
    // Same word in both halves so byte_sel picks the live one
    assign store_line = {wdata_lane, wdata_lane};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[line_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[line_idx] <= fill_data;
            tag_mem[line_idx]  <= line_tag;
        end else if (store_en) begin
            for (int i = 0; i < line_bits / 8; i++) begin
                if (byte_sel[i]) begin
                    data_mem[line_idx][8*i +: 8] <= store_line[8*i +: 8];
                end
            end
        end
    end

    // Controller raises at most one update per ack
    a_single_update: assert property (
        @(posedge clk) disable iff (rst)
        !(fill_en && store_en)
    );

endmodule

// File: hw/dcache_bus_ctrl.sv
`timescale 1ns/1ps

module dcache_bus_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cache_read,
    input  logic                                 cache_write,
    input  logic [dcache_cfg_pkg::xlen-1:0]        addr,
    input  logic [dcache_cfg_pkg::xlen-1:0]        wdata,
    input  lsu_op_pkg::mem_size_e                size,
    input  logic                                 hit,
    output logic                                 fill_en,
    output logic [dcache_cfg_pkg::line_bits-1:0]   fill_data,
    output logic                                 store_en,
    output logic                                 resp_fire,
    output logic                                 fill_bypass,
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic                                 wb_we,
    output logic [dcache_cfg_pkg::xlen-1:0]        wb_adr,
    output logic [dcache_cfg_pkg::line_bits-1:0]   wb_dat_o,
    output logic [dcache_cfg_pkg::line_bits/8-1:0] wb_sel,
    input  logic                                 wb_ack,
    input  logic [dcache_cfg_pkg::line_bits-1:0]   wb_dat_i
);

    import dcache_cfg_pkg::*;
    import lsu_op_pkg::*;

    ctrl_state_e st_ctrl;
    ctrl_state_e st_next;

    logic                   start_fill;
    logic                   start_store;
    logic [3:0]             lane_mask;
    logic [3:0]             lane_sel;
    logic [line_bits/8-1:0] byte_sel;
    logic [xlen-1:0]        wdata_lane;

    assign start_fill  = (st_ctrl == st_idle) && cache_read && !hit;
    assign start_store = (st_ctrl == st_idle) && cache_write;

    // Ack arrives only while the bus cycle is open
    assign fill_en     = (st_ctrl == st_fill) && wb_ack;
    assign store_en    = (st_ctrl == st_store) && wb_ack && hit;
    assign fill_data   = wb_dat_i;
    assign fill_bypass = (st_ctrl == st_fill);
    assign resp_fire   = ((st_ctrl == st_idle) && cache_read && hit) ||
                         (((st_ctrl == st_fill) || (st_ctrl == st_store)) && wb_ack);

    always_comb begin
        st_next = st_ctrl;
        case (st_ctrl)
            st_idle: begin
                if (cache_write) begin
                    st_next = st_store;
                end else if (cache_read) begin
                    st_next = hit ? st_done : st_fill;
                end
            end
            st_fill, st_store: begin
                if (wb_ack) begin
                    st_next = st_done;
                end
            end
            // Hold until the processor drops the request
            st_done: begin
                if (!cache_read && !cache_write) begin
                    st_next = st_idle;
                end
            end
            default: st_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_ctrl <= st_idle;
        end else begin
            st_ctrl <= st_next;
        end
    end

    // Store lanes on the 64-bit bus
    always_comb begin
        case (size)
            size_b, size_bu: lane_mask = sel_byte;
            size_h, size_hu: lane_mask = sel_half;
            default:         lane_mask = sel_word;
        endcase
    end

    assign lane_sel   = lane_mask << addr[1:0];
    assign byte_sel   = addr[2] ? {lane_sel, 4'b0000} : {4'b0000, lane_sel};
    assign wdata_lane = wdata << {addr[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else if (start_fill || start_store) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= start_store;
        end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    end

    // Bus payload latched once per transfer
    always_ff @(posedge clk) begin
        if (start_fill || start_store) begin
            wb_adr   <= {addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
            wb_dat_o <= {wdata_lane, wdata_lane};
            wb_sel   <= start_store ? byte_sel : '1;
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (rst)
        wb_stb |-> wb_cyc
    );

    a_adr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr)
    );

endmodule

// File: hw/dcache_resp_merge.sv
`timescale 1ns/1ps

module dcache_resp_merge (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               resp_fire,
    input  logic                               fill_bypass,
    input  logic [dcache_cfg_pkg::line_bits-1:0] line_data,
    input  logic [dcache_cfg_pkg::line_bits-1:0] fill_data,
    input  logic [dcache_cfg_pkg::xlen-1:0]      addr,
    input  lsu_op_pkg::mem_size_e              size,
    output logic [dcache_cfg_pkg::xlen-1:0]      rdata,
    output logic                               resp_valid
);

    import dcache_cfg_pkg::*;
    import lsu_op_pkg::*;

    logic [line_bits-1:0] src_line;
    logic [xlen-1:0]      word;
    logic [xlen-1:0]      word_shift;
    logic [15:0]          half;
    logic [7:0]           byte_val;
    logic [xlen-1:0]      load_val;

    // On a refill the array has not been written yet
    assign src_line = fill_bypass ? fill_data : line_data;
    assign word     = addr[2] ? src_line[63:32] : src_line[31:0];

    assign word_shift = word >> {addr[1:0], 3'b000};
    assign byte_val   = word_shift[7:0];
    assign half       = addr[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (size)
            size_b:  load_val = {{(xlen-8){byte_val[7]}}, byte_val};
            size_h:  load_val = {{(xlen-16){half[15]}}, half};
            size_bu: load_val = {{(xlen-8){1'b0}}, byte_val};
            size_hu: load_val = {{(xlen-16){1'b0}}, half};
            default: load_val = word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= resp_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            rdata <= load_val;
        end
    end

    // Controller waits for the drop so each request gets one response
    a_resp_pulse: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid
    );

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cache_read,
    input  logic                                 cache_write,
    input  logic [dcache_cfg_pkg::xlen-1:0]        addr,
    input  logic [dcache_cfg_pkg::xlen-1:0]        wdata,
    input  lsu_op_pkg::mem_size_e                size,
    output logic [dcache_cfg_pkg::xlen-1:0]        rdata,
    output logic                                 resp_valid,
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic                                 wb_we,
    output logic [dcache_cfg_pkg::xlen-1:0]        wb_adr,
    output logic [dcache_cfg_pkg::line_bits-1:0]   wb_dat_o,
    output logic [dcache_cfg_pkg::line_bits/8-1:0] wb_sel,
    input  logic                                 wb_ack,
    input  logic [dcache_cfg_pkg::line_bits-1:0]   wb_dat_i
);

    import dcache_cfg_pkg::*;

    logic                 hit;
    logic [line_bits-1:0] line_data;
    logic                 fill_en;
    logic [line_bits-1:0] fill_data;
    logic                 store_en;
    logic                 resp_fire;
    logic                 fill_bypass;

    dcache_array i_array (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .hit       (hit),
        .line_data (line_data),
        .fill_en   (fill_en),
        .fill_data (fill_data),
        .store_en  (store_en),
        .wdata     (wdata),
        .size      (size)
    );

    dcache_bus_ctrl i_bus_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cache_read  (cache_read),
        .cache_write (cache_write),
        .addr        (addr),
        .wdata       (wdata),
        .size        (size),
        .hit         (hit),
        .fill_en     (fill_en),
        .fill_data   (fill_data),
        .store_en    (store_en),
        .resp_fire   (resp_fire),
        .fill_bypass (fill_bypass),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_ack      (wb_ack),
        .wb_dat_i    (wb_dat_i)
    );

    dcache_resp_merge i_resp_merge (
        .clk         (clk),
        .rst         (rst),
        .resp_fire   (resp_fire),
        .fill_bypass (fill_bypass),
        .line_data   (line_data),
        .fill_data   (fill_data),
        .addr        (addr),
        .size        (size),
        .rdata       (rdata),
        .resp_valid  (resp_valid)
    );

endmodule

// File: testbench/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model #(
    parameter int          lines = 512,
    parameter logic [31:0] seed  = 32'h1,
    parameter logic [31:0] mult  = 32'h1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [63:0] dat_w,
    input  logic [7:0]  sel,
    output logic        ack,
    output logic [63:0] dat_r,
    output int          read_count,
    output int          write_count
);

    logic [63:0]              mem [lines];
    logic [31:0]              lcg_state;
    logic [1:0]               wait_left;
    logic [$clog2(lines)-1:0] idx;

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    assign idx = adr[3 +: $clog2(lines)];

    // Slave outputs quiet before the first reset edge
    initial begin
        ack = 1'b0;
        dat_r = '0;
    end

    // Low word is the scrambled byte address and the high word its inverse
    initial begin
        logic [31:0] scr;
        for (int i = 0; i < lines; i++) begin
            scr = (i * 8) * mult;
            mem[i] = {~scr, scr};
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ack         <= 1'b0;
            dat_r       <= '0;
            wait_left   <= 2'd0;
            lcg_state   <= seed;
            read_count  <= 0;
            write_count <= 0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            if (wait_left == 2'd0) begin
                ack <= 1'b1;
                if (we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (sel[b]) begin
                            mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                        end
                    end
                    write_count <= write_count + 1;
                end else begin
                    dat_r      <= mem[idx];
                    read_count <= read_count + 1;
                end
                // Stall of 0 to 3 cycles before the next ack
                lcg_state <= lcg_next(lcg_state);
                wait_left <= lcg_state[17:16];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_cfg_pkg::*;
    import lsu_op_pkg::*;

    localparam logic [31:0] rand_seed    = 32'h92618bce;
    localparam logic [31:0] pattern_mult = 32'h9e3779b1;
    localparam int          mem_lines    = 512;
    localparam int          resp_timeout = 40;
    localparam int          random_ops   = 300;

    logic        clk;
    logic        rst;
    logic        cache_read;
    logic        cache_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    mem_size_e   size;
    logic [31:0] rdata;
    logic        resp_valid;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [63:0] wb_dat_o;
    logic [7:0]  wb_sel;
    logic        wb_ack;
    logic [63:0] wb_dat_i;
    int          read_count;
    int          write_count;

    // Reference memory and cache tag model
    logic [63:0]          shadow [mem_lines];
    logic [num_lines-1:0] model_valid;
    logic [tag_bits-1:0]  model_tag [num_lines];

    logic        req_seen;
    logic        exp_hit;
    logic        exp_load;
    logic [31:0] exp_rdata;
    logic [31:0] exp_adr;
    logic [7:0]  exp_sel;
    logic [63:0] exp_bus;
    logic [63:0] exp_mask;
    logic [31:0] lcg_state;

    int data_errors;
    int bus_errors;
    int count_errors;
    int timeouts;

    dcache_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .cache_read  (cache_read),
        .cache_write (cache_write),
        .addr        (addr),
        .wdata       (wdata),
        .size        (size),
        .rdata       (rdata),
        .resp_valid  (resp_valid),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_ack      (wb_ack),
        .wb_dat_i    (wb_dat_i)
    );

    wb_mem_model #(
        .lines (mem_lines),
        .seed  (rand_seed),
        .mult  (pattern_mult)
    ) i_mem (
        .clk         (clk),
        .rst         (rst),
        .cyc         (wb_cyc),
        .stb         (wb_stb),
        .we          (wb_we),
        .adr         (wb_adr),
        .dat_w       (wb_dat_o),
        .sel         (wb_sel),
        .ack         (wb_ack),
        .dat_r       (wb_dat_i),
        .read_count  (read_count),
        .write_count (write_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] pattern_line(logic [31:0] byte_addr);
        logic [31:0] scr;
        scr = byte_addr * pattern_mult;
        return {~scr, scr};
    endfunction

    function automatic int access_bytes(mem_size_e sz);
        case (sz)
            size_b, size_bu: return 1;
            size_h, size_hu: return 2;
            default:         return 4;
        endcase
    endfunction

    // Little-endian gather of the accessed bytes and then extension
    function automatic logic [31:0] load_value(logic [63:0] line, logic [2:0] off,
                                                mem_size_e sz);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < access_bytes(sz); k++) begin
            v[8*k +: 8] = line[8*(off+k) +: 8];
        end
        if (sz == size_b) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (sz == size_h) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    task automatic access(input logic is_write, input logic [31:0] a,
                          input logic [31:0] wd, input mem_size_e sz);
        int          pos;
        int          rd0;
        int          wr0;
        int          waited;
        logic [3:0]  idx;
        logic        hit_now;
        logic [7:0]  lane_sel;
        logic [63:0] lane_mask;
        logic [63:0] lane_data;

        idx = a[6:3];
        hit_now = !is_write && model_valid[idx] && (model_tag[idx] == a[31:7]);
        lane_sel = '0;
        lane_mask = '0;
        lane_data = '0;
        for (int k = 0; k < access_bytes(sz); k++) begin
            pos = a[2:0] + k;
            lane_sel[pos] = 1'b1;
            lane_mask[8*pos +: 8] = 8'hff;
            lane_data[8*pos +: 8] = wd[8*k +: 8];
        end
        rd0 = read_count;
        wr0 = write_count;

        exp_hit     <= hit_now;
        exp_load    <= !is_write;
        exp_rdata   <= load_value(shadow[a[11:3]], a[2:0], sz);
        exp_adr     <= {a[31:3], 3'b000};
        exp_sel     <= lane_sel;
        exp_bus     <= lane_data;
        exp_mask    <= lane_mask;
        req_seen    <= 1'b1;
        cache_read  <= !is_write;
        cache_write <= is_write;
        addr        <= a;
        wdata       <= wd;
        size        <= sz;

        // Stores reach memory and only read misses allocate
        if (is_write) begin
            shadow[a[11:3]] = (shadow[a[11:3]] & ~lane_mask) | lane_data;
        end else if (!hit_now) begin
            model_valid[idx] = 1'b1;
            model_tag[idx] = a[31:7];
        end

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!resp_valid && waited < resp_timeout);
        if (!resp_valid) begin
            timeouts++;
            $display("No response for address %h within %0d cycles", a, resp_timeout);
        end
        cache_read  <= 1'b0;
        cache_write <= 1'b0;

        assert (read_count - rd0 == ((hit_now || is_write) ? 0 : 1)) else begin
            count_errors++;
            $display("[ERROR] read_count change: got %h expected %h", read_count - rd0,
                     (hit_now || is_write) ? 0 : 1);
        end
        assert (write_count - wr0 == (is_write ? 1 : 0)) else begin
            count_errors++;
            $display("[ERROR] write_count change: got %h expected %h", write_count - wr0,
                     is_write ? 1 : 0);
        end
        @(posedge clk);
    endtask

    // Nine-bit window where four tags share each index
    task automatic random_access();
        logic [31:0] r;
        logic [31:0] a;
        logic        is_write;
        mem_size_e   sz;

        r = lcg_next(lcg_state);
        lcg_state = lcg_next(r);
        is_write = (r[29:28] == 2'b11);
        case (r[18:16] % 5)
            0:       sz = size_b;
            1:       sz = is_write ? size_b : size_bu;
            2:       sz = size_h;
            3:       sz = is_write ? size_h : size_hu;
            default: sz = size_w;
        endcase
        a = {23'd0, r[8:0]};
        if (access_bytes(sz) == 2) begin
            a[0] = 1'b0;
        end else if (access_bytes(sz) == 4) begin
            a[1:0] = 2'b00;
        end
        access(is_write, a, lcg_state, sz);
    endtask

    a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> !wb_cyc && !wb_stb && !resp_valid)
        else begin
            bus_errors++;
            $display("Bus cycle or response seen before the first request");
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        resp_valid && exp_load |-> rdata == exp_rdata)
        else begin
            data_errors++;
            $display("[ERROR] rdata: got %h expected %h", $sampled(rdata), $sampled(exp_rdata));
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(cache_read) && exp_hit |=> resp_valid)
        else begin
            bus_errors++;
            $display("Read hit did not respond in the next cycle");
        end

    a_hit_no_bus: assert property (@(posedge clk) disable iff (rst)
        cache_read && exp_hit |-> !wb_cyc)
        else begin
            bus_errors++;
            $display("Bus cycle started for a read that should hit");
        end

    a_bus_adr: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> wb_adr == exp_adr)
        else begin
            bus_errors++;
            $display("[ERROR] wb_adr: got %h expected %h", $sampled(wb_adr), $sampled(exp_adr));
        end

    a_bus_we: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> wb_we == cache_write)
        else begin
            bus_errors++;
            $display("[ERROR] wb_we: got %h expected %h", $sampled(wb_we),
                     $sampled(cache_write));
        end

    a_store_sel: assert property (@(posedge clk) disable iff (rst)
        wb_stb && wb_we |-> wb_sel == exp_sel)
        else begin
            bus_errors++;
            $display("[ERROR] wb_sel: got %h expected %h", $sampled(wb_sel), $sampled(exp_sel));
        end

    a_store_data: assert property (@(posedge clk) disable iff (rst)
        wb_stb && wb_we |-> (wb_dat_o & exp_mask) == exp_bus)
        else begin
            bus_errors++;
            $display("[ERROR] wb_dat_o: got %h expected %h",
                     $sampled(wb_dat_o) & $sampled(exp_mask), $sampled(exp_bus));
        end

    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                              $stable(wb_sel) && $stable(wb_dat_o))
        else begin
            bus_errors++;
            $display("Wishbone request changed while waiting for ack");
        end

    a_bus_release: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_cyc && !wb_stb)
        else begin
            bus_errors++;
            $display("Wishbone cycle still open after ack");
        end

    initial begin
        rst = 1'b1;
        cache_read = 1'b0;
        cache_write = 1'b0;
        addr = '0;
        wdata = '0;
        size = size_w;
        req_seen = 1'b0;
        exp_hit = 1'b0;
        exp_load = 1'b0;
        exp_rdata = '0;
        exp_adr = '0;
        exp_sel = '0;
        exp_bus = '0;
        exp_mask = '0;
        model_valid = '0;
        lcg_state = rand_seed;
        data_errors = 0;
        bus_errors = 0;
        count_errors = 0;
        timeouts = 0;
        for (int i = 0; i < mem_lines; i++) begin
            shadow[i] = pattern_line(i * 8);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        // Refill then hit on the same line
        access(1'b0, 32'h100, '0, size_w);
        access(1'b0, 32'h104, '0, size_w);

        // Every load size at every legal offset
        access(1'b0, 32'h200, '0, size_w);
        for (int off = 0; off < 8; off++) begin
            access(1'b0, 32'h200 + off, '0, size_b);
            access(1'b0, 32'h200 + off, '0, size_bu);
            if (off % 2 == 0) begin
                access(1'b0, 32'h200 + off, '0, size_h);
                access(1'b0, 32'h200 + off, '0, size_hu);
            end
            if (off % 4 == 0) begin
                access(1'b0, 32'h200 + off, '0, size_w);
            end
        end

        // Store hits merge into the cached line
        access(1'b1, 32'h203, 32'h0000_00a5, size_b);
        access(1'b1, 32'h200, 32'h0000_8e21, size_h);
        access(1'b1, 32'h204, 32'h7c3b_19f0, size_w);
        access(1'b1, 32'h206, 32'h0000_c3f1, size_h);
        access(1'b0, 32'h200, '0, size_w);
        access(1'b0, 32'h204, '0, size_w);
        access(1'b0, 32'h203, '0, size_b);

        // Store miss goes around the cache
        access(1'b1, 32'h388, 32'h1357_9bdf, size_w);
        access(1'b0, 32'h388, '0, size_w);
        access(1'b0, 32'h38a, '0, size_hu);

        for (int n = 0; n < random_ops; n++) begin
            random_access();
        end

        $display("Error counts: data %0d, bus %0d, transfer count %0d, timeouts %0d",
                 data_errors, bus_errors, count_errors, timeouts);
        if (data_errors + bus_errors + count_errors + timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
hw/dcache_cfg_pkg.sv
hw/lsu_op_pkg.sv
hw/dcache_array.sv
hw/dcache_bus_ctrl.sv
hw/dcache_resp_merge.sv
hw/dcache_top.sv
testbench/wb_mem_model.sv
testbench/tb_dcache.sv
